//--- common/decodePkg.sv
package decodePkg;

    localparam int Xlen    = 32;
    localparam int RegIdxW = 5;

    // Major opcodes
    localparam logic [6:0] OpRType  = 7'b0110011;
    localparam logic [6:0] OpIType  = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;

    // ALU funct3 field
    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Sll    = 3'b001;
    localparam logic [2:0] F3Slt    = 3'b010;
    localparam logic [2:0] F3Sltu   = 3'b011;
    localparam logic [2:0] F3Xor    = 3'b100;
    localparam logic [2:0] F3Sr     = 3'b101;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;

    // SUB and SRA
    localparam logic [6:0] F7Alt = 7'b0100000;

    typedef logic [Xlen-1:0]    wordT;
    typedef logic [RegIdxW-1:0] regIdxT;

    typedef enum logic [3:0] {
        AluAdd  = 4'd0,
        AluSub  = 4'd1,
        AluAnd  = 4'd2,
        AluOr   = 4'd3,
        AluXor  = 4'd4,
        AluSll  = 4'd5,
        AluSrl  = 4'd6,
        AluSra  = 4'd7,
        AluSlt  = 4'd8,
        AluSltu = 4'd9,
        AluBeq  = 4'd10,
        AluBne  = 4'd11,
        AluBlt  = 4'd12,
        AluBge  = 4'd13,
        AluBltu = 4'd14,
        AluBgeu = 4'd15
    } aluOpT;

    typedef enum logic [1:0] {
        SelBRs2  = 2'd0,
        SelBImm  = 2'd1,
        SelBFour = 2'd2
    } selBT;

    typedef enum logic [1:0] {
        MemNone     = 2'd0,
        MemReadSext = 2'd1,
        MemReadZext = 2'd2,
        MemWrite    = 2'd3
    } memOpT;

    // Matches the low two bits of the load/store funct3
    typedef enum logic [1:0] {
        SizeByte = 2'd0,
        SizeHalf = 2'd1,
        SizeWord = 2'd2
    } memSizeT;

    typedef enum logic [2:0] {
        ImmNone  = 3'd0,
        ImmI     = 3'd1,
        ImmShamt = 3'd2,
        ImmS     = 3'd3,
        ImmB     = 3'd4,
        ImmU     = 3'd5,
        ImmJ     = 3'd6
    } immKindT;

endpackage

//--- rtl/decode/decodeControl.sv
`timescale 1ns/1ps

module decodeControl (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               flush,
    input  decodePkg::wordT    instr,
    output logic               advance,
    output decodePkg::immKindT immKind,
    output logic               useRs1,
    output logic               useRs2,
    output logic               useRd,
    output decodePkg::aluOpT   aluOp,
    output logic               selA,
    output decodePkg::selBT    selB,
    output logic               aluToReg,
    output decodePkg::memOpT   memOp,
    output decodePkg::memSizeT memSize,
    output logic               branch,
    output logic               jal,
    output logic               jalr
);
    import decodePkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rLegal;
    logic       iShift;
    logic       iLegal;
    logic       discard;

    aluOpT   nextAluOp;
    logic    nextSelA;
    selBT    nextSelB;
    logic    nextAluToReg;
    memOpT   nextMemOp;
    memSizeT nextMemSize;
    logic    nextBranch;
    logic    nextJal;
    logic    nextJalr;

    // Shared by R-type and I-type, alt picks SUB/SRA
    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt);
        case (f3)
            F3AddSub: return alt ? AluSub : AluAdd;
            F3Sll:    return AluSll;
            F3Slt:    return AluSlt;
            F3Sltu:   return AluSltu;
            F3Xor:    return AluXor;
            F3Sr:     return alt ? AluSra : AluSrl;
            F3Or:     return AluOr;
            default:  return AluAnd;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rLegal = (funct7 == 7'b0) ||
                    (funct7 == F7Alt && (funct3 == F3AddSub || funct3 == F3Sr));
    assign iShift = (funct3 == F3Sll) || (funct3 == F3Sr);
    assign iLegal = !iShift || (funct7 == 7'b0) || (funct3 == F3Sr && funct7 == F7Alt);

    always_comb begin
        nextAluOp    = AluAdd;
        nextSelA     = 1'b0;
        nextSelB     = SelBRs2;
        nextAluToReg = 1'b0;
        nextMemOp    = MemNone;
        nextMemSize  = SizeByte;
        nextBranch   = 1'b0;
        nextJal      = 1'b0;
        nextJalr     = 1'b0;
        immKind      = ImmNone;
        useRs1       = 1'b0;
        useRs2       = 1'b0;
        useRd        = 1'b0;

        case (opcode)
            OpRType: begin
                if (rLegal) begin
                    nextAluOp    = aluFromFunct3(funct3, instr[30]);
                    nextAluToReg = 1'b1;
                    useRs1       = 1'b1;
                    useRs2       = 1'b1;
                    useRd        = 1'b1;
                end
            end
            OpIType: begin
                if (iLegal) begin
                    // Bit 30 is immediate data except on right shifts
                    nextAluOp    = aluFromFunct3(funct3, iShift && instr[30]);
                    nextSelB     = SelBImm;
                    nextAluToReg = 1'b1;
                    immKind      = iShift ? ImmShamt : ImmI;
                    useRs1       = 1'b1;
                    useRd        = 1'b1;
                end
            end
            OpLoad: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    nextSelB    = SelBImm;
                    nextMemOp   = funct3[2] ? MemReadZext : MemReadSext;
                    nextMemSize = memSizeT'(funct3[1:0]);
                    immKind     = ImmI;
                    useRs1      = 1'b1;
                    useRd       = 1'b1;
                end
            end
            OpStore: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    nextSelB    = SelBImm;
                    nextMemOp   = MemWrite;
                    nextMemSize = memSizeT'(funct3[1:0]);
                    immKind     = ImmS;
                    useRs1      = 1'b1;
                    useRs2      = 1'b1;
                end
            end
            OpBranch: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    case (funct3)
                        3'b000:  nextAluOp = AluBeq;
                        3'b001:  nextAluOp = AluBne;
                        3'b100:  nextAluOp = AluBlt;
                        3'b101:  nextAluOp = AluBge;
                        3'b110:  nextAluOp = AluBltu;
                        default: nextAluOp = AluBgeu;
                    endcase
                    nextBranch = 1'b1;
                    immKind    = ImmB;
                    useRs1     = 1'b1;
                    useRs2     = 1'b1;
                end
            end
            OpJal: begin
                // Link value is pc + 4
                nextSelA     = 1'b1;
                nextSelB     = SelBFour;
                nextAluToReg = 1'b1;
                nextJal      = 1'b1;
                immKind      = ImmJ;
                useRd        = 1'b1;
            end
            OpJalr: begin
                if (funct3 == 3'b000) begin
                    nextSelA     = 1'b1;
                    nextSelB     = SelBFour;
                    nextAluToReg = 1'b1;
                    nextJalr     = 1'b1;
                    immKind      = ImmI;
                    useRs1       = 1'b1;
                    useRd        = 1'b1;
                end
            end
            OpLui: begin
                nextSelB     = SelBImm;
                nextAluToReg = 1'b1;
                immKind      = ImmU;
                useRd        = 1'b1;
            end
            OpAuipc: begin
                nextSelA     = 1'b1;
                nextSelB     = SelBImm;
                nextAluToReg = 1'b1;
                immKind      = ImmU;
                useRd        = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign advance = !rst && !flush && !stall && !discard;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            aluOp    <= AluAdd;
            selA     <= 1'b0;
            selB     <= SelBRs2;
            aluToReg <= 1'b0;
            memOp    <= MemNone;
            memSize  <= SizeByte;
            branch   <= 1'b0;
            jal      <= 1'b0;
            jalr     <= 1'b0;
        end else if (advance) begin
            aluOp    <= nextAluOp;
            selA     <= nextSelA;
            selB     <= nextSelB;
            aluToReg <= nextAluToReg;
            memOp    <= nextMemOp;
            memSize  <= nextMemSize;
            branch   <= nextBranch;
            jal      <= nextJal;
            jalr     <= nextJalr;
        end
    end

    // Drop the first unstalled slot after a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            discard <= 1'b0;
        end else if (flush) begin
            discard <= 1'b1;
        end else if (!stall) begin
            discard <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0({branch, jal, jalr}));

    assert property (@(posedge clk) disable iff (rst) (memOp == MemWrite) |-> !aluToReg);

endmodule

//--- rtl/decode/immediateGen.sv
`timescale 1ns/1ps

module immediateGen (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               advance,
    input  decodePkg::wordT    instr,
    input  decodePkg::immKindT immKind,
    output decodePkg::wordT    imm
);
    import decodePkg::*;

    wordT immNext;

    always_comb begin
        case (immKind)
            ImmI:     immNext = {{20{instr[31]}}, instr[31:20]};
            ImmShamt: immNext = {27'b0, instr[24:20]};
            ImmS:     immNext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // B and J offsets are in halfwords
            ImmB: begin
                immNext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            ImmJ: begin
                immNext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            end
            ImmU:     immNext = {instr[31:12], 12'b0};
            default:  immNext = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            imm <= '0;
        end else if (advance) begin
            imm <= immNext;
        end
    end

endmodule

//--- rtl/decode/operandLatch.sv
`timescale 1ns/1ps

module operandLatch (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               advance,
    input  decodePkg::wordT    instr,
    input  decodePkg::wordT    pcIn,
    input  logic               useRs1,
    input  logic               useRs2,
    input  logic               useRd,
    output decodePkg::regIdxT  rs1,
    output decodePkg::regIdxT  rs2,
    output decodePkg::regIdxT  rd,
    output decodePkg::wordT    pc
);
    import decodePkg::*;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rs1 <= '0;
            rs2 <= '0;
            rd  <= '0;
            pc  <= '0;
        end else if (advance) begin
            // Unused fields read as x0
            rs1 <= useRs1 ? regIdxT'(instr[19:15]) : '0;
            rs2 <= useRs2 ? regIdxT'(instr[24:20]) : '0;
            rd  <= useRd ? regIdxT'(instr[11:7]) : '0;
            pc  <= pcIn;
        end
    end

    assert property (@(posedge clk) (!advance && !rst && !flush) |=>
                     ($stable(rs1) && $stable(rs2) && $stable(rd) && $stable(pc)));

endmodule

//--- rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               flush,
    input  decodePkg::wordT    instr,
    input  decodePkg::wordT    pcIn,
    output decodePkg::regIdxT  rs1,
    output decodePkg::regIdxT  rs2,
    output decodePkg::regIdxT  rd,
    output decodePkg::wordT    imm,
    output decodePkg::wordT    pc,
    output decodePkg::aluOpT   aluOp,
    output logic               selA,
    output decodePkg::selBT    selB,
    output logic               aluToReg,
    output decodePkg::memOpT   memOp,
    output decodePkg::memSizeT memSize,
    output logic               branch,
    output logic               jal,
    output logic               jalr
);
    import decodePkg::*;

    logic    advance;
    immKindT immKind;
    logic    useRs1;
    logic    useRs2;
    logic    useRd;

    decodeControl uControl (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .flush    (flush),
        .instr    (instr),
        .advance  (advance),
        .immKind  (immKind),
        .useRs1   (useRs1),
        .useRs2   (useRs2),
        .useRd    (useRd),
        .aluOp    (aluOp),
        .selA     (selA),
        .selB     (selB),
        .aluToReg (aluToReg),
        .memOp    (memOp),
        .memSize  (memSize),
        .branch   (branch),
        .jal      (jal),
        .jalr     (jalr)
    );

    immediateGen uImmGen (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .advance (advance),
        .instr   (instr),
        .immKind (immKind),
        .imm     (imm)
    );

    operandLatch uOperands (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .advance (advance),
        .instr   (instr),
        .pcIn    (pcIn),
        .useRs1  (useRs1),
        .useRs2  (useRs2),
        .useRd   (useRd),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .pc      (pc)
    );

endmodule

//--- dv/decodeRef.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected outputs of the decode stage for one instruction
typedef struct {
    regIdxT  rs1;
    regIdxT  rs2;
    regIdxT  rd;
    wordT    imm;
    wordT    pc;
    aluOpT   aluOp;
    logic    selA;
    selBT    selB;
    logic    aluToReg;
    memOpT   memOp;
    memSizeT memSize;
    logic    branch;
    logic    jal;
    logic    jalr;
} decodeExpT;

// Output state after reset or flush
function automatic decodeExpT idleExp();
    decodeExpT e;
    e.rs1      = '0;
    e.rs2      = '0;
    e.rd       = '0;
    e.imm      = '0;
    e.pc       = '0;
    e.aluOp    = AluAdd;
    e.selA     = 1'b0;
    e.selB     = SelBRs2;
    e.aluToReg = 1'b0;
    e.memOp    = MemNone;
    e.memSize  = SizeByte;
    e.branch   = 1'b0;
    e.jal      = 1'b0;
    e.jalr     = 1'b0;
    return e;
endfunction

// RV32I OP / OP-IMM operation for a funct3 value
function automatic aluOpT aluOpFor(input logic [2:0] f3, input logic alt);
    case (f3)
        3'b000:  return alt ? AluSub : AluAdd;
        3'b001:  return AluSll;
        3'b010:  return AluSlt;
        3'b011:  return AluSltu;
        3'b100:  return AluXor;
        3'b101:  return alt ? AluSra : AluSrl;
        3'b110:  return AluOr;
        default: return AluAnd;
    endcase
endfunction

function automatic decodeExpT refDecode(input wordT in, input wordT pcv);
    decodeExpT  e;
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       shift;
    wordT       immI;
    wordT       immS;
    wordT       immB;
    wordT       immJ;
    wordT       immU;
    op    = in[6:0];
    f3    = in[14:12];
    f7    = in[31:25];
    shift = (f3 == 3'b001) || (f3 == 3'b101);
    immI  = {{20{in[31]}}, in[31:20]};
    immS  = {{20{in[31]}}, in[31:25], in[11:7]};
    immB  = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
    immJ  = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
    immU  = {in[31:12], 12'h000};
    e     = idleExp();
    e.pc  = pcv;
    case (op)
        OpRType: begin
            if (f7 == 7'b0 || (f7 == F7Alt && (f3 == 3'b000 || f3 == 3'b101))) begin
                e.aluOp    = aluOpFor(f3, f7 == F7Alt);
                e.aluToReg = 1'b1;
                e.rs1      = in[19:15];
                e.rs2      = in[24:20];
                e.rd       = in[11:7];
            end
        end
        OpIType: begin
            if (!shift || f7 == 7'b0 || (f3 == 3'b101 && f7 == F7Alt)) begin
                e.aluOp    = aluOpFor(f3, shift && f7 == F7Alt);
                e.selB     = SelBImm;
                e.aluToReg = 1'b1;
                e.imm      = shift ? {27'b0, in[24:20]} : immI;
                e.rs1      = in[19:15];
                e.rd       = in[11:7];
            end
        end
        OpLoad: begin
            if (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                e.selB    = SelBImm;
                e.memOp   = f3[2] ? MemReadZext : MemReadSext;
                e.memSize = (f3[1:0] == 2'b00) ? SizeByte :
                            (f3[1:0] == 2'b01) ? SizeHalf : SizeWord;
                e.imm     = immI;
                e.rs1     = in[19:15];
                e.rd      = in[11:7];
            end
        end
        OpStore: begin
            if (f3 inside {3'b000, 3'b001, 3'b010}) begin
                e.selB    = SelBImm;
                e.memOp   = MemWrite;
                e.memSize = (f3 == 3'b000) ? SizeByte : (f3 == 3'b001) ? SizeHalf : SizeWord;
                e.imm     = immS;
                e.rs1     = in[19:15];
                e.rs2     = in[24:20];
            end
        end
        OpBranch: begin
            if (f3 != 3'b010 && f3 != 3'b011) begin
                case (f3)
                    3'b000:  e.aluOp = AluBeq;
                    3'b001:  e.aluOp = AluBne;
                    3'b100:  e.aluOp = AluBlt;
                    3'b101:  e.aluOp = AluBge;
                    3'b110:  e.aluOp = AluBltu;
                    default: e.aluOp = AluBgeu;
                endcase
                e.branch = 1'b1;
                e.imm    = immB;
                e.rs1    = in[19:15];
                e.rs2    = in[24:20];
            end
        end
        OpJal: begin
            e.selA     = 1'b1;
            e.selB     = SelBFour;
            e.aluToReg = 1'b1;
            e.jal      = 1'b1;
            e.imm      = immJ;
            e.rd       = in[11:7];
        end
        OpJalr: begin
            if (f3 == 3'b000) begin
                e.selA     = 1'b1;
                e.selB     = SelBFour;
                e.aluToReg = 1'b1;
                e.jalr     = 1'b1;
                e.imm      = immI;
                e.rs1      = in[19:15];
                e.rd       = in[11:7];
            end
        end
        OpLui, OpAuipc: begin
            // AUIPC adds to the PC, LUI to x0
            e.selA     = (op == OpAuipc);
            e.selB     = SelBImm;
            e.aluToReg = 1'b1;
            e.imm      = immU;
            e.rd       = in[11:7];
        end
        default: begin
        end
    endcase
    return e;
endfunction

`endif

//--- dv/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb;
    import decodePkg::*;

    `include "decodeRef.svh"

    localparam int AluCount     = 200;
    localparam int MemCount     = 100;
    localparam int CtrlCount    = 100;
    localparam int StallRounds  = 20;
    localparam int MaxStall     = 8;
    localparam int FlushRounds  = 10;
    localparam int UnknownCount = 40;
    localparam int TestCycles   = 3 + AluCount + MemCount + CtrlCount
                                + StallRounds * (1 + MaxStall) + FlushRounds * 7
                                + UnknownCount + 2 + 6 + 2;
    localparam int CycleLimit   = 2 * TestCycles + 50;

    logic    clk;
    logic    rst;
    logic    stall;
    logic    flush;
    wordT    instr;
    wordT    pcIn;
    regIdxT  rs1;
    regIdxT  rs2;
    regIdxT  rd;
    wordT    imm;
    wordT    pc;
    aluOpT   aluOp;
    logic    selA;
    selBT    selB;
    logic    aluToReg;
    memOpT   memOp;
    memSizeT memSize;
    logic    branch;
    logic    jal;
    logic    jalr;

    decodeExpT   model;
    logic        discardPending;
    logic        checking = 1'b0;
    logic [31:0] rngState = 32'he45;
    wordT        pcCount  = 32'h0000_1000;
    string       testName = "reset";
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;

    decodeStage u_dut (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .flush    (flush),
        .instr    (instr),
        .pcIn     (pcIn),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .pc       (pc),
        .aluOp    (aluOp),
        .selA     (selA),
        .selB     (selB),
        .aluToReg (aluToReg),
        .memOp    (memOp),
        .memSize  (memSize),
        .branch   (branch),
        .jal      (jal),
        .jalr     (jalr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] randBits();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic wordT nextPc();
        pcCount = pcCount + 32'd4;
        return pcCount;
    endfunction

    // OP or OP-IMM with legal funct7 on SUB, SRA, SRAI and shifts
    function automatic wordT randAluInstr();
        wordT       w;
        logic [2:0] f3;
        logic       alt;
        w   = randBits();
        f3  = w[14:12];
        alt = w[30];
        if (w[0]) begin
            w[6:0]   = OpRType;
            w[31:25] = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? F7Alt : 7'b0;
        end else begin
            w[6:0] = OpIType;
            if (f3 == 3'b001 || f3 == 3'b101) begin
                w[31:25] = (alt && f3 == 3'b101) ? F7Alt : 7'b0;
            end
        end
        return w;
    endfunction

    function automatic wordT randMemInstr();
        wordT        w;
        logic [31:0] pick;
        w    = randBits();
        pick = randBits();
        if (w[0]) begin
            w[6:0] = OpLoad;
            case (pick % 5)
                0:       w[14:12] = 3'b000;
                1:       w[14:12] = 3'b001;
                2:       w[14:12] = 3'b010;
                3:       w[14:12] = 3'b100;
                default: w[14:12] = 3'b101;
            endcase
        end else begin
            w[6:0]   = OpStore;
            w[14:12] = 3'(pick % 3);
        end
        return w;
    endfunction

    function automatic wordT randCtrlInstr();
        wordT        w;
        logic [31:0] pick;
        logic [2:0]  f3;
        w    = randBits();
        pick = randBits();
        // Branch funct3 skips the two reserved codes
        f3   = 3'(pick[15:8] % 6);
        case (pick % 5)
            0: begin
                w[6:0]   = OpBranch;
                w[14:12] = (f3 < 3'd2) ? f3 : f3 + 3'd2;
            end
            1: w[6:0] = OpJal;
            2: begin
                w[6:0]   = OpJalr;
                w[14:12] = 3'b000;
            end
            3:       w[6:0] = OpLui;
            default: w[6:0] = OpAuipc;
        endcase
        return w;
    endfunction

    function automatic wordT randAnyInstr();
        logic [31:0] pick;
        pick = randBits();
        case (pick % 3)
            0:       return randAluInstr();
            1:       return randMemInstr();
            default: return randCtrlInstr();
        endcase
    endfunction

    function automatic wordT randUnknownInstr();
        wordT w;
        w = randBits();
        if (w[6:0] inside {OpRType, OpIType, OpLoad, OpStore, OpBranch, OpJal, OpJalr,
                           OpLui, OpAuipc}) begin
            w[6:0] = 7'b1111111;
        end
        return w;
    endfunction

    task automatic checkWord(input string what, input wordT expV, input wordT actV);
        checkCount++;
        if (actV !== expV) begin
            errorCount++;
            $display("[ERROR] %s %s: expected %h, actual %h", testName, what, expV, actV);
        end
    endtask

    task automatic checkReg(input string what, input regIdxT expV, input regIdxT actV);
        checkCount++;
        if (actV !== expV) begin
            errorCount++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", testName, what, expV, actV);
        end
    endtask

    task automatic checkAluOp(input aluOpT expV, input aluOpT actV);
        checkCount++;
        if (actV !== expV) begin
            errorCount++;
            $display("[ERROR] %s aluOp: expected %s, actual %s", testName, expV.name(),
                     actV.name());
        end
    endtask

    task automatic checkSelB(input selBT expV, input selBT actV);
        checkCount++;
        if (actV !== expV) begin
            errorCount++;
            $display("[ERROR] %s selB: expected %s, actual %s", testName, expV.name(),
                     actV.name());
        end
    endtask

    task automatic checkMem(input memOpT expOp, input memSizeT expSize,
                            input memOpT actOp, input memSizeT actSize);
        checkCount++;
        if (actOp !== expOp || actSize !== expSize) begin
            errorCount++;
            $display("[ERROR] %s mem: expected %s/%s, actual %s/%s", testName, expOp.name(),
                     expSize.name(), actOp.name(), actSize.name());
        end
    endtask

    task automatic checkBit(input string what, input logic expV, input logic actV);
        checkCount++;
        if (actV !== expV) begin
            errorCount++;
            $display("[ERROR] %s %s: expected %b, actual %b", testName, what, expV, actV);
        end
    endtask

    task automatic compareAll();
        checkReg("rs1", model.rs1, rs1);
        checkReg("rs2", model.rs2, rs2);
        checkReg("rd", model.rd, rd);
        checkWord("imm", model.imm, imm);
        checkWord("pc", model.pc, pc);
        checkAluOp(model.aluOp, aluOp);
        checkBit("selA", model.selA, selA);
        checkSelB(model.selB, selB);
        checkBit("aluToReg", model.aluToReg, aluToReg);
        checkMem(model.memOp, model.memSize, memOp, memSize);
        checkBit("branch", model.branch, branch);
        checkBit("jal", model.jal, jal);
        checkBit("jalr", model.jalr, jalr);
    endtask

    // Expected stage state, one item in flight
    always @(posedge clk) begin
        if (rst) begin
            model          = idleExp();
            discardPending = 1'b0;
        end else if (flush) begin
            model          = idleExp();
            discardPending = 1'b1;
        end else if (!stall) begin
            if (discardPending) begin
                discardPending = 1'b0;
            end else begin
                model = refDecode(instr, pcIn);
            end
        end
    end

    always @(negedge clk) begin
        if (checking) begin
            compareAll();
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: tests did not finish within %0d cycles", CycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic present(input wordT w, input wordT p);
        @(posedge clk);
        instr <= w;
        pcIn  <= p;
        stall <= 1'b0;
        flush <= 1'b0;
    endtask

    // Lets the last instruction land and be checked before the next test
    task automatic finishTest();
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
    endtask

    initial begin
        int   n;
        wordT keepPc;
        rst   = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        instr = '0;
        pcIn  = '0;
        repeat (3) @(posedge clk);
        rst      <= 1'b0;
        checking <= 1'b1;

        testName = "alu";
        repeat (AluCount) present(randAluInstr(), nextPc());
        finishTest();

        testName = "loadStore";
        repeat (MemCount) present(randMemInstr(), nextPc());
        finishTest();

        testName = "branchJump";
        repeat (CtrlCount) present(randCtrlInstr(), nextPc());
        finishTest();

        testName = "stall";
        repeat (StallRounds) begin
            present(randAnyInstr(), nextPc());
            n = int'(randBits() % MaxStall) + 1;
            repeat (n) begin
                @(posedge clk);
                stall <= 1'b1;
                instr <= randBits();
                pcIn  <= randBits();
            end
        end
        finishTest();

        testName = "flush";
        repeat (FlushRounds) begin
            present(randAnyInstr(), nextPc());
            @(posedge clk);
            flush <= 1'b1;
            instr <= randAnyInstr();
            pcIn  <= nextPc();
            n = int'(randBits() % 3);
            repeat (n) begin
                @(posedge clk);
                flush <= 1'b0;
                stall <= 1'b1;
                instr <= randAnyInstr();
            end
            present(randAnyInstr(), nextPc());
            keepPc = nextPc();
            present(randAnyInstr(), keepPc);
            @(negedge clk);
            checkWord("dropped pc", '0, pc);
            checkBit("dropped aluToReg", 1'b0, aluToReg);
            finishTest();
            checkWord("kept pc", keepPc, pc);
        end
        finishTest();

        testName = "unknown";
        repeat (UnknownCount) present(randUnknownInstr(), nextPc());
        // FENCE and ECALL
        present(32'h0ff0000f, nextPc());
        present(32'h00000073, nextPc());
        finishTest();

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- rvDecode.f
+incdir+dv
common/decodePkg.sv
rtl/decode/decodeControl.sv
rtl/decode/immediateGen.sv
rtl/decode/operandLatch.sv
rtl/decodeStage.sv
dv/decodeStageTb.sv

//--- Bender.yml
package:
  name: rvDecode

sources:
  - files:
      - common/decodePkg.sv
      - rtl/decode/decodeControl.sv
      - rtl/decode/immediateGen.sv
      - rtl/decode/operandLatch.sv
      - rtl/decodeStage.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/decodeStageTb.sv
